// File: hdl/core_pkg.sv
// core shared definitions
package core_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // rv32i major opcodes
  localparam logic [6:0] op_r      = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [3:0] alu_add = 4'd0;
  localparam logic [3:0] alu_sub = 4'd1;
  localparam logic [3:0] alu_and = 4'd2;
  localparam logic [3:0] alu_or  = 4'd3;
  localparam logic [3:0] alu_xor = 4'd4;
  localparam logic [3:0] alu_sll = 4'd5;
  localparam logic [3:0] alu_srl = 4'd6;
  localparam logic [3:0] alu_slt = 4'd7;

  // operand source in execute
  localparam logic [1:0] fwd_none = 2'd0;
  localparam logic [1:0] fwd_mem  = 2'd1;
  localparam logic [1:0] fwd_wb   = 2'd2;

  localparam logic [reg_addr_w-1:0] halt_reg  = 5'd17;
  localparam logic [xlen-1:0]       halt_code = 32'd10;
  localparam logic [xlen-1:0]       reset_pc  = '0;
  localparam logic [31:0]           nop_word  = 32'h0000_0013; // addi x0, x0, 0

  // one instruction word, read as register form or immediate form
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } i;
  } inst_t;

endpackage

// File: hdl/alu.sv
// integer ALU and branch compare
module alu import core_pkg::*; (
  input  logic [3:0]      op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  logic [2:0]      funct3,
  output logic [xlen-1:0] result,
  output logic            take
);

  logic lt;

  assign lt = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_sll: result = a << b[4:0];
      alu_srl: result = a >> b[4:0];
      alu_slt: result = {{(xlen-1){1'b0}}, lt};
      default: result = a + b;
    endcase
  end

  // only meaningful for branches
  always_comb begin
    case (funct3)
      3'b000:  take = (a == b); // beq
      3'b001:  take = (a != b); // bne
      3'b100:  take = lt;       // blt
      3'b101:  take = !lt;      // bge
      default: take = 1'b0;
    endcase
  end

endmodule

// File: hdl/fetch_stage.sv
// instruction fetch
module fetch_stage import core_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            stall_if,
  input  logic            freeze,
  input  logic            flush_id,
  input  logic            redirect,
  input  logic            halted,
  input  logic [xlen-1:0] redirect_pc,
  input  logic [xlen-1:0] imem_data,
  output logic [xlen-1:0] imem_addr,
  output inst_t           id_inst,
  output logic [xlen-1:0] id_pc,
  output logic            id_valid
);

  logic [xlen-1:0] pc;

  assign imem_addr = pc; // instruction comes back in the same cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (!freeze) begin
      if (redirect) begin
        pc <= redirect_pc;
      end else if (!stall_if && !halted) begin
        pc <= pc + 32'd4; // not-taken prediction
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      id_valid <= 1'b0;
      id_inst  <= nop_word;
    end else if (!freeze) begin
      if (flush_id || halted) begin
        id_valid <= 1'b0; // wrong path or stopped
        id_inst  <= nop_word;
      end else if (!stall_if) begin
        id_valid <= 1'b1;
        id_inst  <= imem_data;
        id_pc    <= pc;
      end
    end
  end

endmodule

// File: hdl/decode_stage.sv
// instruction decode and register file
module decode_stage import core_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  freeze,
  input  logic                  stall_id,
  input  logic                  flush_ex,
  input  logic                  id_valid,
  input  inst_t                 id_inst,
  input  logic [xlen-1:0]       id_pc,
  input  logic                  wb_we,
  input  logic [reg_addr_w-1:0] wb_rd,
  input  logic [xlen-1:0]       wb_data,
  output logic [reg_addr_w-1:0] id_rs1,
  output logic [reg_addr_w-1:0] id_rs2,
  output logic [reg_addr_w-1:0] ex_rs1,
  output logic [reg_addr_w-1:0] ex_rs2,
  output logic [reg_addr_w-1:0] ex_rd,
  output logic [xlen-1:0]       ex_rs1_val,
  output logic [xlen-1:0]       ex_rs2_val,
  output logic [xlen-1:0]       ex_imm,
  output logic [xlen-1:0]       ex_pc,
  output logic [3:0]            ex_alu_op,
  output logic                  ex_alu_src,
  output logic                  ex_reg_we,
  output logic                  ex_load,
  output logic                  ex_store,
  output logic                  ex_branch,
  output logic                  ex_jal,
  output logic                  ex_jalr,
  output logic                  ex_ecall,
  output logic [2:0]            ex_funct3
);

  inst_t           inst;
  logic [xlen-1:0] regs [32];
  logic [xlen-1:0] rs1_val, rs2_val, imm;
  logic [3:0]      alu_op, arith_op;
  logic            alu_src, reg_we, load, store, branch, jal, jalr, ecall;
  logic            wb_hit1, wb_hit2;

  assign inst = id_valid ? id_inst : nop_word;

  // register form subtracts when funct7 bit 5 is set
  always_comb begin
    case (inst.r.funct3)
      3'b000:  arith_op = (inst.r.opcode == op_r && inst.r.funct7[5]) ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = alu_srl;
      3'b110:  arith_op = alu_or;
      3'b111:  arith_op = alu_and;
      default: arith_op = alu_add;
    endcase
  end

  always_comb begin
    id_rs1  = '0;
    id_rs2  = '0;
    imm     = {{20{inst.i.imm[11]}}, inst.i.imm};
    alu_op  = alu_add;
    alu_src = 1'b1;
    reg_we  = 1'b0;
    load    = 1'b0;
    store   = 1'b0;
    branch  = 1'b0;
    jal     = 1'b0;
    jalr    = 1'b0;
    ecall   = 1'b0;
    case (inst.r.opcode)
      op_r: begin
        id_rs1  = inst.r.rs1;
        id_rs2  = inst.r.rs2;
        alu_op  = arith_op;
        alu_src = 1'b0;
        reg_we  = 1'b1;
      end
      op_imm: begin
        id_rs1 = inst.i.rs1;
        alu_op = arith_op;
        reg_we = 1'b1;
      end
      op_load: begin
        id_rs1 = inst.i.rs1;
        reg_we = 1'b1;
        load   = 1'b1;
      end
      op_store: begin
        id_rs1 = inst.r.rs1;
        id_rs2 = inst.r.rs2;
        imm    = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rd};
        store  = 1'b1;
      end
      op_branch: begin
        id_rs1  = inst.r.rs1;
        id_rs2  = inst.r.rs2;
        imm     = {{19{inst.r.funct7[6]}}, inst.r.funct7[6], inst.r.rd[0],
                   inst.r.funct7[5:0], inst.r.rd[4:1], 1'b0};
        alu_op  = alu_sub;
        alu_src = 1'b0;
        branch  = 1'b1;
      end
      op_jal: begin
        imm    = {{11{inst.i.imm[11]}}, inst.i.imm[11], inst.r.rs1, inst.r.funct3,
                  inst.i.imm[0], inst.i.imm[10:1], 1'b0};
        reg_we = 1'b1;
        jal    = 1'b1;
      end
      op_jalr: begin
        id_rs1 = inst.i.rs1;
        reg_we = 1'b1;
        jalr   = 1'b1;
      end
      op_system: begin
        if (inst.i.funct3 == 3'b000 && inst.i.imm == 12'd0) begin
          id_rs1 = halt_reg; // ecall looks at x17
          ecall  = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // register file with write-through on a same-cycle read
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < 32; k++) regs[k] <= '0;
    end else if (wb_we && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  assign wb_hit1 = wb_we && wb_rd == id_rs1;
  assign wb_hit2 = wb_we && wb_rd == id_rs2;
  assign rs1_val = (id_rs1 == '0) ? '0 : (wb_hit1 ? wb_data : regs[id_rs1]);
  assign rs2_val = (id_rs2 == '0) ? '0 : (wb_hit2 ? wb_data : regs[id_rs2]);

  always_ff @(posedge clk) begin
    if (reset) begin
      {ex_reg_we, ex_load, ex_store, ex_branch, ex_jal, ex_jalr, ex_ecall} <= '0;
      ex_rs1 <= '0;
      ex_rs2 <= '0;
      ex_rd  <= '0;
    end else if (freeze) begin
      // operands held while a write leaving writeback still lands in them
      if (wb_we && wb_rd != '0 && wb_rd == ex_rs1) ex_rs1_val <= wb_data;
      if (wb_we && wb_rd != '0 && wb_rd == ex_rs2) ex_rs2_val <= wb_data;
    end else if (flush_ex || stall_id) begin
      {ex_reg_we, ex_load, ex_store, ex_branch, ex_jal, ex_jalr, ex_ecall} <= '0;
      ex_rs1 <= '0;
      ex_rs2 <= '0;
      ex_rd  <= '0;
    end else begin
      {ex_reg_we, ex_load, ex_store} <= {reg_we, load, store};
      {ex_branch, ex_jal, ex_jalr, ex_ecall} <= {branch, jal, jalr, ecall};
      ex_rs1     <= id_rs1;
      ex_rs2     <= id_rs2;
      ex_rd      <= reg_we ? inst.r.rd : '0;
      ex_rs1_val <= rs1_val;
      ex_rs2_val <= rs2_val;
      ex_imm     <= imm;
      ex_pc      <= id_pc;
      ex_alu_op  <= alu_op;
      ex_alu_src <= alu_src;
      ex_funct3  <= inst.r.funct3;
    end
  end

endmodule

// File: hdl/execute_stage.sv
// execute with forwarding and branch resolution
module execute_stage import core_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  freeze,
  input  logic [reg_addr_w-1:0] ex_rs1,
  input  logic [reg_addr_w-1:0] ex_rs2,
  input  logic [reg_addr_w-1:0] ex_rd,
  input  logic [xlen-1:0]       ex_rs1_val,
  input  logic [xlen-1:0]       ex_rs2_val,
  input  logic [xlen-1:0]       ex_imm,
  input  logic [xlen-1:0]       ex_pc,
  input  logic [3:0]            ex_alu_op,
  input  logic                  ex_alu_src,
  input  logic                  ex_reg_we,
  input  logic                  ex_load,
  input  logic                  ex_store,
  input  logic                  ex_branch,
  input  logic                  ex_jal,
  input  logic                  ex_jalr,
  input  logic                  ex_ecall,
  input  logic [2:0]            ex_funct3,
  input  logic [1:0]            fwd_a,
  input  logic [1:0]            fwd_b,
  input  logic [xlen-1:0]       wb_data,
  output logic                  redirect,
  output logic [xlen-1:0]       redirect_pc,
  output logic                  halt_hit,
  output logic [reg_addr_w-1:0] mem_rd,
  output logic [xlen-1:0]       mem_result,
  output logic [xlen-1:0]       mem_wdata,
  output logic                  mem_reg_we,
  output logic                  mem_load,
  output logic                  mem_store
);

  logic [xlen-1:0] opa, opb, alu_b, alu_result, jalr_target;
  logic            take;

  // the memory-stage value is this stage's own output register
  assign opa = (fwd_a == fwd_mem) ? mem_result : (fwd_a == fwd_wb) ? wb_data : ex_rs1_val;
  assign opb = (fwd_b == fwd_mem) ? mem_result : (fwd_b == fwd_wb) ? wb_data : ex_rs2_val;
  assign alu_b = ex_alu_src ? ex_imm : opb;

  alu alu_i (
    .op     (ex_alu_op),
    .a      (opa),
    .b      (alu_b),
    .funct3 (ex_funct3),
    .result (alu_result),
    .take   (take)
  );

  assign jalr_target = (opa + ex_imm) & ~32'd1;
  assign redirect    = (ex_branch && take) || ex_jal || ex_jalr;
  assign redirect_pc = ex_jalr ? jalr_target : ex_pc + ex_imm;
  assign halt_hit    = ex_ecall && (opa == halt_code); // opa carries x17 here

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_reg_we <= 1'b0;
      mem_load   <= 1'b0;
      mem_store  <= 1'b0;
      mem_rd     <= '0;
    end else if (!freeze) begin
      mem_reg_we <= ex_reg_we;
      mem_load   <= ex_load;
      mem_store  <= ex_store;
      mem_rd     <= ex_rd;
      mem_result <= (ex_jal || ex_jalr) ? ex_pc + 32'd4 : alu_result; // link value
      mem_wdata  <= opb;
    end
  end

endmodule

// File: hdl/memory_stage.sv
// data memory access and writeback register
module memory_stage import core_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [reg_addr_w-1:0] mem_rd,
  input  logic [xlen-1:0]       mem_result,
  input  logic [xlen-1:0]       mem_wdata,
  input  logic                  mem_reg_we,
  input  logic                  mem_load,
  input  logic                  mem_store,
  input  logic                  dmem_ack,
  input  logic [xlen-1:0]       dmem_rdata,
  output logic                  dmem_req,
  output logic                  dmem_we,
  output logic                  mem_busy,
  output logic [xlen-1:0]       dmem_addr,
  output logic [xlen-1:0]       dmem_wdata,
  output logic                  wb_we,
  output logic [reg_addr_w-1:0] wb_rd,
  output logic [xlen-1:0]       wb_data
);

  logic            ack_wait_low; // req dropped, waiting for ack to fall
  logic            done;
  logic [xlen-1:0] load_data;

  // EX/MEM is frozen for the whole access, so these hold still
  assign dmem_addr  = mem_result;
  assign dmem_wdata = mem_wdata;
  assign dmem_we    = mem_store;

  assign done     = ack_wait_low && !dmem_ack;
  assign mem_busy = (mem_load || mem_store) && !done;

  // idle, then req high until ack, then req low until ack falls
  always_ff @(posedge clk) begin
    if (reset) begin
      dmem_req     <= 1'b0;
      ack_wait_low <= 1'b0;
    end else if (dmem_req) begin
      if (dmem_ack) begin
        dmem_req     <= 1'b0;
        ack_wait_low <= 1'b1;
      end
    end else if (ack_wait_low) begin
      if (!dmem_ack) ack_wait_low <= 1'b0;
    end else if (mem_load || mem_store) begin
      dmem_req <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (dmem_req && dmem_ack) load_data <= dmem_rdata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_we <= 1'b0;
      wb_rd <= '0;
    end else if (mem_busy) begin
      wb_we <= 1'b0; // bubble into writeback while waiting
    end else begin
      wb_we   <= mem_reg_we;
      wb_rd   <= mem_rd;
      wb_data <= mem_load ? load_data : mem_result;
    end
  end

endmodule

// File: hdl/pipeline_control.sv
// hazard, forwarding and halt control
module pipeline_control import core_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [reg_addr_w-1:0] id_rs1,
  input  logic [reg_addr_w-1:0] id_rs2,
  input  logic [reg_addr_w-1:0] ex_rs1,
  input  logic [reg_addr_w-1:0] ex_rs2,
  input  logic [reg_addr_w-1:0] ex_rd,
  input  logic [reg_addr_w-1:0] mem_rd,
  input  logic [reg_addr_w-1:0] wb_rd,
  input  logic                  ex_load,
  input  logic                  mem_reg_we,
  input  logic                  wb_we,
  input  logic                  redirect,
  input  logic                  halt_hit,
  input  logic                  mem_busy,
  output logic                  stall_if,
  output logic                  stall_id,
  output logic                  flush_id,
  output logic                  flush_ex,
  output logic                  freeze,
  output logic                  halted,
  output logic [1:0]            fwd_a,
  output logic [1:0]            fwd_b
);

  logic load_use;
  logic mem_ok, wb_ok;

  // load in execute feeding the instruction in decode
  assign load_use = ex_load && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);
  assign stall_if = load_use;
  assign stall_id = load_use;

  assign flush_id = redirect || halt_hit; // two younger instructions go
  assign flush_ex = redirect || halt_hit;
  assign freeze   = mem_busy;

  assign mem_ok = mem_reg_we && mem_rd != '0;
  assign wb_ok  = wb_we && wb_rd != '0;

  // memory stage is younger, so it wins
  assign fwd_a = (mem_ok && mem_rd == ex_rs1) ? fwd_mem :
                 (wb_ok && wb_rd == ex_rs1)   ? fwd_wb  : fwd_none;
  assign fwd_b = (mem_ok && mem_rd == ex_rs2) ? fwd_mem :
                 (wb_ok && wb_rd == ex_rs2)   ? fwd_wb  : fwd_none;

  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (halt_hit && !freeze) begin
      halted <= 1'b1; // sticky until reset
    end
  end

endmodule

// File: hdl/pipelined_core.sv
// five-stage rv32i core
module pipelined_core import core_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  output logic [xlen-1:0]       imem_addr,
  input  logic [xlen-1:0]       imem_data,
  output logic                  dmem_req,
  output logic                  dmem_we,
  output logic [xlen-1:0]       dmem_addr,
  output logic [xlen-1:0]       dmem_wdata,
  input  logic                  dmem_ack,
  input  logic [xlen-1:0]       dmem_rdata,
  output logic                  retire_valid,
  output logic [reg_addr_w-1:0] retire_rd,
  output logic [xlen-1:0]       retire_data,
  output logic                  halted
);

  // IF/ID
  inst_t                 id_inst;
  logic [xlen-1:0]       id_pc;
  logic                  id_valid;
  logic [reg_addr_w-1:0] id_rs1, id_rs2;

  // ID/EX
  logic [reg_addr_w-1:0] ex_rs1, ex_rs2, ex_rd;
  logic [xlen-1:0]       ex_rs1_val, ex_rs2_val, ex_imm, ex_pc;
  logic [3:0]            ex_alu_op;
  logic [2:0]            ex_funct3;
  logic                  ex_alu_src, ex_reg_we, ex_load, ex_store;
  logic                  ex_branch, ex_jal, ex_jalr, ex_ecall;
  logic                  redirect, halt_hit;
  logic [xlen-1:0]       redirect_pc;

  // EX/MEM and MEM/WB
  logic [reg_addr_w-1:0] mem_rd, wb_rd;
  logic [xlen-1:0]       mem_result, mem_wdata, wb_data;
  logic                  mem_reg_we, mem_load, mem_store, mem_busy, wb_we;

  // control
  logic                  stall_if, stall_id, flush_id, flush_ex, freeze;
  logic [1:0]            fwd_a, fwd_b;

  fetch_stage fetch_stage_i (.*);

  decode_stage decode_stage_i (.*);

  execute_stage execute_stage_i (.*);

  memory_stage memory_stage_i (.*);

  pipeline_control pipeline_control_i (.*);

  // writeback bus is the retire port
  assign retire_valid = wb_we && wb_rd != '0;
  assign retire_rd    = wb_rd;
  assign retire_data  = wb_data;

endmodule

// File: tb/pipelined_core_chk.sv
// memory handshake and retire checks
module pipelined_core_chk import core_pkg::*; (
  input logic                  clk,
  input logic                  reset,
  input logic                  dmem_req,
  input logic                  dmem_ack,
  input logic                  dmem_we,
  input logic [xlen-1:0]       dmem_addr,
  input logic [xlen-1:0]       dmem_wdata,
  input logic                  retire_valid,
  input logic [reg_addr_w-1:0] retire_rd
);
  timeunit 1ns;
  timeprecision 1ps;

  int   fail_count = 0;
  logic in_reset; // reset also high at the previous edge

  always_ff @(posedge clk) in_reset <= reset;

  req_held: assert property (@(posedge clk) disable iff (reset)
    dmem_req && !dmem_ack |=> dmem_req)
    else begin
      $error("dmem_req fell before dmem_ack was seen");
      fail_count++;
    end

  req_stable: assert property (@(posedge clk) disable iff (reset)
    dmem_req ##1 dmem_req |-> $stable(dmem_addr) && $stable(dmem_we) && $stable(dmem_wdata))
    else begin
      $error("dmem address, direction or write data moved while dmem_req was high");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge clk)
    reset && in_reset |-> !retire_valid && !dmem_req)
    else begin
      $error("retire_valid or dmem_req high during reset");
      fail_count++;
    end

  // no retire while a data access holds the pipeline
  retire_legal: assert property (@(posedge clk) disable iff (reset)
    retire_valid |-> retire_rd != '0 && !dmem_req)
    else begin
      $error("retire_valid with retire_rd equal to x0 or during an open data access");
      fail_count++;
    end

endmodule

bind pipelined_core pipelined_core_chk pipelined_core_chk_i (.*);

// File: tb/pipelined_core_tb.sv
// pipelined core testbench
module pipelined_core_tb import core_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_inst       = 150;
  localparam int n_rand       = n_inst - 2; // then addi x17 and ecall
  localparam int reset_cycles = 10;
  localparam int max_cycles   = n_inst * 20 + reset_cycles;

  logic                  clk, reset, dmem_req, dmem_we, dmem_ack, retire_valid, halted;
  logic [xlen-1:0]       imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
  logic [xlen-1:0]       retire_data;
  logic [reg_addr_w-1:0] retire_rd;

  logic [31:0] prog [n_inst];
  logic [31:0] p_imm [n_inst]; // immediate each instruction was built with
  logic [31:0] data_mem [64];
  int unsigned ack_delay [256];
  int          delay_idx = 0;
  int          cycles = 0;
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_data_q [$];
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_wdata_q [$];

  pipelined_core pipelined_core_i (.*);

  always #10 clk = ~clk;

  // combinational instruction memory with nops past the end
  assign imem_data = (imem_addr[31:2] < n_inst) ? prog[imem_addr[31:2]] : nop_word;

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic int next_delay();
    int d;
    d = ack_delay[delay_idx];
    delay_idx = (delay_idx + 1) % 256;
    return d;
  endfunction

  // few registers so dependencies are frequent
  function automatic logic [4:0] pick_reg();
    int r;
    r = $urandom_range(0, 8);
    return (r == 8) ? halt_reg : 5'(r);
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    inst_t w;
    w.r = {f7, rs2, rs1, f3, rd, op};
    return w;
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    inst_t w;
    w.i = {imm, rs1, f3, rd, op};
    return w;
  endfunction

  task automatic gen_program();
    int          kind, tgt;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [11:0] r12;
    logic [31:0] imm;
    for (int k = 0; k < n_rand; k++) begin
      kind = $urandom_range(0, 99);
      rd   = pick_reg();
      rs1  = pick_reg();
      rs2  = pick_reg();
      f3   = $urandom_range(0, 7);
      r12  = $urandom;
      imm  = {{20{r12[11]}}, r12};
      tgt  = k + 1 + $urandom_range(0, 7);
      if (tgt > n_rand) tgt = n_rand; // never skips the closing addi
      if (f3 == 3'b011) f3 = 3'b000;
      if (kind < 28) begin
        prog[k] = enc_r((f3 == 3'b000 && r12[0]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, op_r);
      end else if (kind < 52) begin
        if (f3 == 3'b001 || f3 == 3'b101) imm = imm & 32'd31; // shift amount
        prog[k] = enc_i(imm[11:0], rs1, f3, rd, op_imm);
      end else if (kind < 64) begin
        imm = 4 * $urandom_range(0, 63);
        prog[k] = enc_i(imm[11:0], 5'd0, 3'b010, rd, op_load);
      end else if (kind < 76) begin
        imm = 4 * $urandom_range(0, 63);
        prog[k] = enc_r(imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], op_store);
      end else if (kind < 88) begin
        imm = (tgt - k) * 4;
        f3  = {r12[1], 1'b0, r12[2]}; // beq, bne, blt, bge
        prog[k] = enc_r({imm[12], imm[10:5]}, rs2, rs1, f3, {imm[4:1], imm[11]}, op_branch);
      end else if (kind < 93) begin
        imm = (tgt - k) * 4;
        prog[k] = {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
      end else if (kind < 97) begin
        imm = tgt * 4; // absolute target on an x0 base
        prog[k] = enc_i(imm[11:0], 5'd0, 3'b000, rd, op_jalr);
      end else begin
        imm = 0;
        prog[k] = enc_i(12'd0, 5'd0, 3'b000, 5'd0, op_system);
      end
      p_imm[k] = imm;
    end
    prog[n_rand]      = enc_i(halt_code[11:0], 5'd0, 3'b000, halt_reg, op_imm);
    p_imm[n_rand]     = halt_code;
    prog[n_rand + 1]  = enc_i(12'd0, 5'd0, 3'b000, 5'd0, op_system);
    p_imm[n_rand + 1] = 0;
  endtask

  // ISA model filling the expected write and store lists
  task automatic run_model();
    logic [31:0] x [32];
    logic [31:0] mem [64];
    logic [31:0] a, b, res;
    inst_t       w;
    int          pc, npc;
    bit          done, wr, take;
    foreach (x[r]) x[r] = '0;
    foreach (mem[m]) mem[m] = fill_word(m * 4);
    pc   = 0;
    done = 0;
    while (!done && pc < n_inst) begin
      w   = prog[pc];
      a   = x[w.r.rs1];
      b   = x[w.r.rs2];
      wr  = 0;
      res = '0;
      npc = pc + 1;
      case (w.r.opcode)
        op_r, op_imm: begin
          if (w.i.opcode == op_imm) b = p_imm[pc];
          wr = 1;
          case (w.r.funct3)
            3'b000:  res = (w.r.opcode == op_r && w.r.funct7[5]) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101:  res = a >> b[4:0];
            3'b110:  res = a | b;
            default: res = a & b;
          endcase
        end
        op_load: begin
          wr  = 1;
          res = mem[p_imm[pc][7:2]];
        end
        op_store: begin
          exp_addr_q.push_back(p_imm[pc]);
          exp_wdata_q.push_back(b);
          mem[p_imm[pc][7:2]] = b;
        end
        op_branch: begin
          case (w.r.funct3)
            3'b000:  take = (a == b);
            3'b001:  take = (a != b);
            3'b100:  take = ($signed(a) < $signed(b));
            default: take = ($signed(a) >= $signed(b));
          endcase
          if (take) npc = pc + p_imm[pc] / 4;
        end
        op_jal, op_jalr: begin
          wr  = 1;
          res = (pc + 1) * 4; // link
          npc = (w.r.opcode == op_jal) ? pc + p_imm[pc] / 4 : p_imm[pc] / 4;
        end
        default: done = (x[halt_reg] == halt_code); // ecall
      endcase
      if (wr && w.i.rd != 5'd0) begin
        x[w.i.rd] = res;
        exp_rd_q.push_back(w.i.rd);
        exp_data_q.push_back(res);
      end
      pc = npc;
    end
  endtask

  initial begin
    void'($urandom(23));
    clk        = 1'b0;
    reset      = 1'b1;
    dmem_ack   = 1'b0;
    dmem_rdata = '0;
    foreach (data_mem[m]) data_mem[m] = fill_word(m * 4);
    foreach (ack_delay[d]) ack_delay[d] = $urandom_range(0, 3);
    gen_program();
    run_model();
    repeat (reset_cycles) @(posedge clk);
    #1 reset = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (!halted);
    repeat (30) @(posedge clk); // older instructions drain
    #1;
    if (exp_rd_q.size() == 0 && exp_addr_q.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      fail_run("the core halted with expected writes or stores still outstanding");
    end
  end

  initial begin : retire_monitor
    forever begin
      @(posedge clk);
      #1;
      if (!reset && retire_valid) begin
        if (exp_rd_q.size() == 0) begin
          fail_run("a register write retired after the last expected write");
        end else begin
          check_value("retire_rd", retire_rd, exp_rd_q.pop_front());
          check_value("retire_data", retire_data, exp_data_q.pop_front());
        end
      end
    end
  end

  // four-phase data memory with random ack delays
  initial begin : dmem_responder
    int idx;
    forever begin
      @(posedge clk);
      #1;
      if (!reset && dmem_req) begin
        repeat (next_delay()) begin
          @(posedge clk);
          #1;
        end
        if (dmem_addr > 32'd252 || dmem_addr[1:0] != 2'b00) begin
          fail_run("a data access fell outside the 64-word window");
        end
        idx = dmem_addr[7:2];
        if (dmem_we) begin
          if (exp_addr_q.size() == 0) begin
            fail_run("a store reached memory beyond the expected list");
          end else begin
            check_value("dmem_addr", dmem_addr, exp_addr_q.pop_front());
            check_value("dmem_wdata", dmem_wdata, exp_wdata_q.pop_front());
          end
          data_mem[idx] = dmem_wdata;
        end else begin
          dmem_rdata = data_mem[idx];
        end
        dmem_ack = 1'b1;
        do begin
          @(posedge clk);
          #1;
        end while (dmem_req);
        repeat (next_delay()) begin
          @(posedge clk);
          #1;
        end
        dmem_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    forever begin
      @(posedge clk);
      #2;
      cycles++;
      if (pipelined_core_i.pipelined_core_chk_i.fail_count != 0) begin
        fail_run("an assertion on the memory handshake or retire port failed");
      end
      if (cycles >= max_cycles) begin
        fail_run($sformatf("timeout, the core did not halt within %0d cycles", max_cycles));
      end
    end
  end

endmodule

// File: pipelined_core.f
hdl/core_pkg.sv
hdl/alu.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/pipeline_control.sv
hdl/pipelined_core.sv
tb/pipelined_core_chk.sv
tb/pipelined_core_tb.sv

// File: Bender.yml
package:
  name: pipelined_core

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/alu.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/memory_stage.sv
      - hdl/pipeline_control.sv
      - hdl/pipelined_core.sv
  - target: test
    files:
      - tb/pipelined_core_chk.sv
      - tb/pipelined_core_tb.sv
